// File: source/doppler_defines.svh
`ifndef DOPPLER_DEFINES_SVH
`define DOPPLER_DEFINES_SVH

// one SPI word, also the number of LEDs
`define DOPPLER_WORD_BITS 16

`define DOPPLER_SYNC_STAGES 2 // flops per input synchronizer

// 5 bits -> one scan step every 32 clocks
`define DOPPLER_SCAN_DIV_BITS 5

`define DOPPLER_MATRIX_DIM 4 // rows and columns of the LED matrix

`endif

// File: source/doppler_pkg.sv
`default_nettype none

`include "doppler_defines.svh"

package doppler_pkg;

  // SPI shift registers, LED register and pin snapshot
  typedef logic [`DOPPLER_WORD_BITS-1:0] spi_word_t;

  typedef logic [`DOPPLER_MATRIX_DIM-1:0] matrix_line_t; // one bit per column or row

  // LED index, row = idx / dim, column = idx % dim
  typedef logic [$clog2(`DOPPLER_WORD_BITS)-1:0] scan_idx_t;

  typedef logic [`DOPPLER_SYNC_STAGES-1:0] sync_chain_t; // one synchronizer chain

  // one-hot line with a single bit set at pos
  function automatic matrix_line_t line_select(input int unsigned pos);
    return matrix_line_t'(1) << pos;
  endfunction

endpackage

`default_nettype wire

// File: source/spi_events_if.sv
`timescale 1ns/1ps
`default_nettype none

// synchronized SPI events, all in the clk domain
interface spi_events_if;
  logic sck_rise; // single-cycle strobe
  logic cs_rise;  // single-cycle strobe, frame end
  logic cs_fall;  // single-cycle strobe, frame start
  logic mosi;     // settled data level

  modport sync_side (
    output sck_rise,
    output cs_rise,
    output cs_fall,
    output mosi
  );

  modport shift_side (
    input sck_rise,
    input cs_rise,
    input cs_fall,
    input mosi
  );
endinterface

`default_nettype wire

// File: source/spi_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "doppler_defines.svh"

module spi_sync (
  input  logic            clk,
  input  logic            rst,
  input  logic            sck_in,
  input  logic            cs_in,
  input  logic            mosi_in,
  spi_events_if.sync_side ev
);
  import doppler_pkg::*;

  localparam int LAST = `DOPPLER_SYNC_STAGES - 1;

  sync_chain_t sck_sync;
  sync_chain_t cs_sync;
  sync_chain_t mosi_sync;
  logic        sck_hist; // previous settled sck
  logic        cs_hist;  // previous settled cs

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync  <= '0;
      cs_sync   <= '1; // bus idles with cs high
      mosi_sync <= '0;
      sck_hist  <= 1'b0;
      cs_hist   <= 1'b1;
    end else begin
      // async pins enter at bit 0, settled value leaves at LAST
      sck_sync  <= {sck_sync[LAST-1:0], sck_in};
      cs_sync   <= {cs_sync[LAST-1:0], cs_in};
      mosi_sync <= {mosi_sync[LAST-1:0], mosi_in};
      sck_hist  <= sck_sync[LAST];
      cs_hist   <= cs_sync[LAST];
    end
  end

  // strobes come straight from the flops, two clocks after the pin moves
  assign ev.sck_rise = sck_sync[LAST] & ~sck_hist;
  assign ev.cs_rise  = cs_sync[LAST] & ~cs_hist;
  assign ev.cs_fall  = ~cs_sync[LAST] & cs_hist;

  assign ev.mosi = mosi_sync[LAST]; // same latency as the sck strobe

endmodule

`default_nettype wire

// File: source/spi_shift.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift (
  input  logic                  clk,
  input  logic                  rst,
  spi_events_if.shift_side      ev,
  input  doppler_pkg::spi_word_t pins,
  output logic                  so,
  output logic                  led_wr,
  output doppler_pkg::spi_word_t led_word
);
  import doppler_pkg::*;

  localparam int WORD_W = $bits(spi_word_t);

  spi_word_t rx_shift; // MOSI bits, newest at bit 0
  spi_word_t tx_shift; // MISO bits, MSB goes out first

  // cs_rise wins over cs_fall, cs_fall over sck_rise
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_shift <= '0;
      tx_shift <= '1; // so reads high while idle
      led_wr   <= 1'b0;
    end else begin
      led_wr <= 1'b0;
      if (ev.cs_rise) begin
        led_wr <= 1'b1; // frame done, hand the word to the matrix
      end else if (ev.cs_fall) begin
        tx_shift <= pins; // snapshot of the input pins
      end else if (ev.sck_rise) begin
        // longer frames simply push the early bits out the top
        rx_shift <= {rx_shift[WORD_W-2:0], ev.mosi};
        tx_shift <= {tx_shift[WORD_W-2:0], 1'b1};
      end
    end
  end

  // word stays valid alongside the led_wr pulse
  always_ff @(posedge clk) begin
    if (ev.cs_rise) begin
      led_word <= rx_shift;
    end
  end

  assign so = tx_shift[WORD_W-1];

endmodule

`default_nettype wire

// File: source/led_matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "doppler_defines.svh"

// 4x4 matrix, one LED lit at a time
// anodes are active low, cathode rows drive output enables of the pads
module led_matrix_scan (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      led_wr,
  input  doppler_pkg::spi_word_t    led_word,
  output doppler_pkg::matrix_line_t aled,
  output doppler_pkg::matrix_line_t kled_tri
);
  import doppler_pkg::*;

  localparam int DIM = `DOPPLER_MATRIX_DIM;

  logic [`DOPPLER_SCAN_DIV_BITS-1:0] prescale;
  logic                              scan_tick;
  spi_word_t                         led_reg;
  scan_idx_t                         scan_idx;
  matrix_line_t                      col_sel;
  matrix_line_t                      row_sel;
  logic                              led_on;

  // LED register, written once per SPI frame
  always_ff @(posedge clk) begin
    if (rst) begin
      led_reg <= '0;
    end else if (led_wr) begin
      led_reg <= led_word;
    end
  end

  // free running prescaler, tick on the last count before wrap
  always_ff @(posedge clk) begin
    if (rst) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  assign scan_tick = &prescale;

  // decode of the current LED position
  assign col_sel = line_select(scan_idx % DIM);
  assign row_sel = line_select(scan_idx / DIM);
  assign led_on  = led_reg[scan_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      scan_idx <= '0;
      aled     <= '1; // all anodes off
      kled_tri <= '0; // all cathodes floating
    end else if (scan_tick) begin
      aled     <= ~col_sel;
      kled_tri <= led_on ? row_sel : '0;
      scan_idx <= scan_idx + 1'b1; // wraps after the last LED
    end
  end

endmodule

`default_nettype wire

// File: source/doppler_io_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "doppler_defines.svh"

// SPI slave to LED matrix, pin snapshot read back on MISO
module doppler_io_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cfg_sck,
  input  logic                           cfg_cs,
  input  logic                           cfg_si,
  output logic                           cfg_so,
  input  logic [`DOPPLER_WORD_BITS-1:0]  pins,
  output logic [`DOPPLER_MATRIX_DIM-1:0] aled,
  output logic [`DOPPLER_MATRIX_DIM-1:0] kled_tri
);
  import doppler_pkg::*;

  logic      led_wr;   // one clock per finished frame
  spi_word_t led_word;

  spi_events_if spi_ev ();

  spi_sync u_spi_sync (
    .clk     (clk),
    .rst     (rst),
    .sck_in  (cfg_sck),
    .cs_in   (cfg_cs),
    .mosi_in (cfg_si),
    .ev      (spi_ev.sync_side)
  );

  spi_shift u_spi_shift (
    .clk      (clk),
    .rst      (rst),
    .ev       (spi_ev.shift_side),
    .pins     (pins),
    .so       (cfg_so),
    .led_wr   (led_wr),
    .led_word (led_word)
  );

  // cs rise to LED register update is 4 clocks through sync and shifter
  led_matrix_scan u_led_matrix_scan (
    .clk      (clk),
    .rst      (rst),
    .led_wr   (led_wr),
    .led_word (led_word),
    .aled     (aled),
    .kled_tri (kled_tri)
  );

endmodule

`default_nettype wire

// File: test/tb_spi_tasks.svh
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// included inside tb_doppler_io and uses its clock and DUT signals

task automatic wait_clocks(input int n);
  repeat (n) @(posedge clk);
endtask

task automatic check_word(input string name, input spi_word_t actual,
                          input spi_word_t expected);
  if (actual !== expected) begin
    $display("FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual);
    abort_run();
  end
endtask

task automatic check_line(input string name, input matrix_line_t actual,
                          input matrix_line_t expected);
  if (actual !== expected) begin
    $display("FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual);
    abort_run();
  end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    $display("FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual);
    abort_run();
  end
endtask

// position of the lowest set bit or -1 for an empty line
function automatic int line_pos(input matrix_line_t line);
  int           pos;
  matrix_line_t probe;
  pos = -1;
  for (int k = DIM - 1; k >= 0; k--) begin
    probe = line >> k;
    if (probe[0]) pos = k;
  end
  return pos;
endfunction

// one SPI frame sent MSB first with sck half periods of 8 clocks
task automatic drive_frame(input int bits, input logic [31:0] mosi_word,
                           input spi_word_t pin_val);
  logic [31:0] shifted;
  logic        want;
  shifted = mosi_word << (32 - bits); // first bit to send at bit 31
  @(posedge clk);
  pins <= pin_val;
  wait_clocks(4);
  cfg_cs <= 1'b0; // slave samples the pins here
  wait_clocks(4);
  pins <= ~pin_val; // pins move once the snapshot is held
  for (int i = 0; i < bits; i++) begin
    wait_clocks(8);
    cfg_sck <= 1'b0;
    cfg_si  <= shifted[31];
    shifted = shifted << 1;
    wait_clocks(8);
    @(negedge clk);
    // pin bits come out MSB first and ones follow
    if (i < WORD_BITS) want = pin_val[scan_idx_t'(WORD_BITS - 1 - i)];
    else want = 1'b1;
    check_bit($sformatf("cfg_so bit %0d", i), cfg_so, want);
    @(posedge clk);
    cfg_sck <= 1'b1;
  end
  wait_clocks(8);
  cfg_sck <= 1'b0;
  wait_clocks(8);
  @(negedge clk);
  if (bits >= WORD_BITS) check_bit("cfg_so after frame", cfg_so, 1'b1);
  @(posedge clk);
  cfg_cs <= 1'b1; // frame end hands the word to the LED register
endtask

// watch 16 scan steps and rebuild the LED register from aled and kled_tri
task automatic verify_scan(input spi_word_t expected);
  matrix_line_t prev_aled;
  matrix_line_t want_aled;
  spi_word_t    seen;
  scan_idx_t    led_idx;
  int           steps;
  int           next_col;
  int           row;
  seen  = '0;
  steps = 0;
  @(negedge clk);
  prev_aled = aled;
  while (steps < WORD_BITS) begin
    @(negedge clk);
    if (aled != prev_aled) begin
      // columns count up from 0 after reset and wrap after the last one
      if (prev_aled == '1) next_col = 0;
      else next_col = (line_pos(~prev_aled) + 1) % DIM;
      want_aled = ~(matrix_line_t'(1) << next_col);
      check_line("aled", aled, want_aled);
      if (kled_tri != '0) begin
        if ($countones(kled_tri) != 1) begin
          $display("kled_tri 0x%h drives more than one row at once", kled_tri);
          abort_run();
        end
        row     = line_pos(kled_tri);
        led_idx = scan_idx_t'(row * DIM + next_col);
        if (seen[led_idx]) begin
          $display("LED at row %0d column %0d lit twice in one scan", row, next_col);
          abort_run();
        end
        seen[led_idx] = 1'b1;
      end
      prev_aled = aled;
      steps++;
    end
  end
  check_word("LED register seen in scan", seen, expected);
endtask

`endif

// File: test/tb_doppler_io.sv
`timescale 1ns/1ps
`default_nettype none

`include "doppler_defines.svh"

module tb_doppler_io;
  import doppler_pkg::*;

  localparam int DIM       = `DOPPLER_MATRIX_DIM;
  localparam int WORD_BITS = `DOPPLER_WORD_BITS;
  localparam int MAX_CASES = 32;
  localparam int FIELDS    = 4;   // bits, mosi word, pins, led register
  localparam int SCAN_WAIT = 640; // 16 steps of 32 clocks plus alignment
  localparam logic [31:0] END_MARK = 32'hff;

  logic         clk;
  logic         rst;
  logic         cfg_sck;
  logic         cfg_cs;
  logic         cfg_si;
  logic         cfg_so;
  spi_word_t    pins;
  matrix_line_t aled;
  matrix_line_t kled_tri;

  logic [31:0] case_mem [0:MAX_CASES*FIELDS-1];
  int          num_cases;
  int          cycle_count = 0;
  int          cycle_limit = 100000; // replaced once the cases are read

  doppler_io_top u_doppler_io_top (
    .clk      (clk),
    .rst      (rst),
    .cfg_sck  (cfg_sck),
    .cfg_cs   (cfg_cs),
    .cfg_si   (cfg_si),
    .cfg_so   (cfg_so),
    .pins     (pins),
    .aled     (aled),
    .kled_tri (kled_tri)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  task automatic abort_run;
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  `include "tb_spi_tasks.svh"

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d clocks, the test did not finish", cycle_count);
      abort_run();
    end
  end

  initial begin
    int          bits;
    logic [31:0] mosi_word;
    spi_word_t   pin_val;
    spi_word_t   led_exp;
    rst     = 1'b1;
    cfg_sck = 1'b0;
    cfg_cs  = 1'b1; // bus idle
    cfg_si  = 1'b0;
    pins    = '0;

    $readmemh("test/spi_cases.txt", case_mem);
    num_cases   = 0;
    cycle_limit = 2000; // reset and the idle scan
    while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] != END_MARK) begin
      bits        = int'(case_mem[num_cases*FIELDS]);
      cycle_limit = cycle_limit + bits * 16 + 64 + SCAN_WAIT;
      num_cases++;
    end
    if (num_cases == 0) begin
      $display("no cases found in test/spi_cases.txt");
      abort_run();
    end

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // idle state, nothing lit before the first frame
    @(negedge clk);
    check_line("aled", aled, '1);
    check_line("kled_tri", kled_tri, '0);
    check_bit("cfg_so", cfg_so, 1'b1);
    verify_scan('0);

    for (int n = 0; n < num_cases; n++) begin
      bits      = int'(case_mem[n*FIELDS]);
      mosi_word = case_mem[n*FIELDS+1];
      pin_val   = spi_word_t'(case_mem[n*FIELDS+2]);
      led_exp   = spi_word_t'(case_mem[n*FIELDS+3]);
      if (bits > 32) begin
        $display("case %0d asks for %0d bits, at most 32 fit in one line", n, bits);
        abort_run();
      end
      $display("case %0d: %0d bits, mosi 0x%h, pins 0x%h", n, bits, mosi_word, pin_val);
      drive_frame(bits, mosi_word, pin_val);
      wait_clocks(6); // register is written 4 clocks after cs rises
      verify_scan(led_exp);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
+incdir+test
source/doppler_pkg.sv
source/spi_events_if.sv
source/spi_sync.sv
source/spi_shift.sv
source/led_matrix_scan.sv
source/doppler_io_top.sv
test/tb_doppler_io.sv

// File: Makefile
# Verilator build and run of the doppler_io testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

obj_dir/Vtb_doppler_io: flist.f source/*.sv source/*.svh test/*.sv test/*.svh
	verilator --binary --timing -sv -f flist.f --top-module tb_doppler_io -Mdir obj_dir

# pass only when the run prints the pass line
test: obj_dir/Vtb_doppler_io test/spi_cases.txt
	@out="$$(./obj_dir/Vtb_doppler_io 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: test/spi_cases.txt
// bits  mosi word  pins  expected led register, all hex
// a bit count of ff ends the list
10 0000a5c3 1234 a5c3
10 0000ffff 8001 ffff
10 00000001 f0f0 0001
14 000abcde 5a5a bcde
00 00000000 00ff bcde
10 00008421 0f0f 8421
10 00000000 ffff 0000
14 000f1234 c3c3 1234
10 00006996 7e81 6996
00 00000000 1111 6996
ff 00000000 0000 0000
